//--- verilog/wbPkg.sv
package wbPkg;

    localparam int dataWidth   = 32;                // machine word.
    localparam int regIdxWidth = 5;                 // gpr index bits.
    localparam int regCount    = 2 ** regIdxWidth;  // 32 general registers.
    localparam int linkOffset  = 8;                 // return address past the delay slot.

    typedef logic [dataWidth-1:0]   word_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;

    // access width of a load.
    typedef enum logic [1:0] {
        sizeByte = 2'd0,    // lb / lbu.
        sizeHalf = 2'd1,    // lh / lhu.
        sizeWord = 2'd2     // lw.
    } loadSize_t;

    typedef struct packed {
        logic      signExt; // 1 for lb / lh.
        loadSize_t size;
    } loadType_t;

    // write enables, already resolved against exceptions in MEM.
    typedef struct packed {
        logic rfWr;         // general register file.
        logic hiWr;
        logic loWr;
    } regsWr_t;

    // source of the value written to the register file.
    typedef enum logic [1:0] {
        selAlu  = 2'd0,     // alu result.
        selLoad = 2'd1,     // aligned load data.
        selLink = 2'd2,     // pc + 8 for jal / jalr / bal.
        selOutB = 2'd3      // second operand, moves.
    } wbSel_t;

endpackage

//--- verilog/wbBus.sv
`timescale 1ns/1ps

interface wbBus;
    import wbPkg::*;

    word_t     aluOut;      // alu result, also the load address.
    word_t     outB;        // second operand.
    word_t     dmOut;       // raw data memory word.
    word_t     pc;
    word_t     hi;          // value for hi.
    word_t     lo;          // value for lo.
    regIdx_t   dst;         // destination gpr.
    wbSel_t    wbSel;
    loadType_t loadType;
    regsWr_t   regsWr;

    modport producer (
        output aluOut, outB, dmOut, pc, hi, lo,
        output dst, wbSel, loadType, regsWr
    );

    modport consumer (
        input aluOut, outB, dmOut, pc, hi, lo,
        input dst, wbSel, loadType, regsWr
    );

endinterface

//--- verilog/wbStageReg.sv
`timescale 1ns/1ps

module wbStageReg (
    input logic      clk,
    input logic      rstN,
    input logic      wbFlush,       // level, kills the slot.
    input logic      wbWr,          // level, low means stall.
    wbBus.consumer   memSide,
    wbBus.producer   wbSide
);
    import wbPkg::*;

    logic clear;

    assign clear = !rstN || wbFlush;    // flush wins over write.

    always_ff @(posedge clk) begin
        if (clear) begin
            wbSide.aluOut   <= '0;
            wbSide.outB     <= '0;
            wbSide.dmOut    <= '0;
            wbSide.pc       <= '0;
            wbSide.hi       <= '0;
            wbSide.lo       <= '0;
            wbSide.dst      <= '0;
            wbSide.wbSel    <= selAlu;
            wbSide.loadType <= '0;
            wbSide.regsWr   <= '0;      // bubble, writes nothing.
        end else if (wbWr) begin
            wbSide.aluOut   <= memSide.aluOut;
            wbSide.outB     <= memSide.outB;
            wbSide.dmOut    <= memSide.dmOut;
            wbSide.pc       <= memSide.pc;
            wbSide.hi       <= memSide.hi;
            wbSide.lo       <= memSide.lo;
            wbSide.dst      <= memSide.dst;
            wbSide.wbSel    <= memSide.wbSel;
            wbSide.loadType <= memSide.loadType;
            wbSide.regsWr   <= memSide.regsWr;
        end
        // otherwise hold, the pipeline is stalled.
    end

endmodule

//--- verilog/wbResult.sv
`timescale 1ns/1ps

module wbResult (
    wbBus.consumer        wbSide,
    output wbPkg::word_t  wbValue
);
    import wbPkg::*;

    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    word_t       loadData;
    word_t       linkAddr;

    // little endian, address from the alu result.
    always_comb begin
        case (wbSide.aluOut[1:0])
            2'd0:    byteLane = wbSide.dmOut[7:0];
            2'd1:    byteLane = wbSide.dmOut[15:8];
            2'd2:    byteLane = wbSide.dmOut[23:16];
            default: byteLane = wbSide.dmOut[31:24];
        endcase
    end

    assign halfLane = wbSide.aluOut[1] ? wbSide.dmOut[31:16] : wbSide.dmOut[15:0];

    always_comb begin
        case (wbSide.loadType.size)
            sizeByte: begin
                if (wbSide.loadType.signExt) begin
                    loadData = {{24{byteLane[7]}}, byteLane};      // lb.
                end else begin
                    loadData = {24'd0, byteLane};                  // lbu.
                end
            end
            sizeHalf: begin
                if (wbSide.loadType.signExt) begin
                    loadData = {{16{halfLane[15]}}, halfLane};     // lh.
                end else begin
                    loadData = {16'd0, halfLane};                  // lhu.
                end
            end
            default: loadData = wbSide.dmOut;                      // lw.
        endcase
    end

    assign linkAddr = wbSide.pc + word_t'(linkOffset);

    always_comb begin
        case (wbSide.wbSel)
            selAlu:  wbValue = wbSide.aluOut;
            selLoad: wbValue = loadData;
            selLink: wbValue = linkAddr;
            default: wbValue = wbSide.outB;                        // mthi/mtlo style moves.
        endcase
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    wbBus.consumer         wbSide,
    input  wbPkg::word_t   wbValue,     // finished writeback value.
    input  wbPkg::regIdx_t rAddr1,
    input  wbPkg::regIdx_t rAddr2,
    output wbPkg::word_t   rData1,
    output wbPkg::word_t   rData2,
    output wbPkg::word_t   hiOut,
    output wbPkg::word_t   loOut
);
    import wbPkg::*;

    word_t regs [regCount];
    word_t hiReg;
    word_t loReg;
    logic  gprWr;

    assign gprWr = wbSide.regsWr.rfWr && (wbSide.dst != '0);  // r0 is never written.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (gprWr) begin
                regs[wbSide.dst] <= wbValue;
            end
            if (wbSide.regsWr.hiWr) begin
                hiReg <= wbSide.hi;
            end
            if (wbSide.regsWr.loWr) begin
                loReg <= wbSide.lo;
            end
        end
    end

    // read with bypass of the value being written back.
    always_comb begin
        if (gprWr && rAddr1 == wbSide.dst) begin
            rData1 = wbValue;
        end else begin
            rData1 = regs[rAddr1];      // r0 keeps its reset zero.
        end
    end

    always_comb begin
        if (gprWr && rAddr2 == wbSide.dst) begin
            rData2 = wbValue;
        end else begin
            rData2 = regs[rAddr2];
        end
    end

    assign hiOut = wbSide.regsWr.hiWr ? wbSide.hi : hiReg;     // hi bypass.
    assign loOut = wbSide.regsWr.loWr ? wbSide.lo : loReg;     // lo bypass.

endmodule

//--- verilog/wbTop.sv
`timescale 1ns/1ps

module wbTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wbFlush,
    input  logic              wbWr,
    input  wbPkg::word_t      memAluOut,
    input  wbPkg::word_t      memOutB,
    input  wbPkg::word_t      memDmOut,
    input  wbPkg::word_t      memPc,
    input  wbPkg::word_t      memHi,
    input  wbPkg::word_t      memLo,
    input  wbPkg::regIdx_t    memDst,
    input  wbPkg::wbSel_t     memWbSel,
    input  wbPkg::loadType_t  memLoadType,
    input  wbPkg::regsWr_t    memRegsWr,
    input  wbPkg::regIdx_t    rAddr1,
    input  wbPkg::regIdx_t    rAddr2,
    output wbPkg::word_t      rData1,
    output wbPkg::word_t      rData2,
    output wbPkg::word_t      hiOut,
    output wbPkg::word_t      loOut
);
    import wbPkg::*;

    wbBus memSide ();       // MEM stage outputs.
    wbBus wbSide ();        // registered WB stage.

    word_t wbValue;

    assign memSide.aluOut   = memAluOut;
    assign memSide.outB     = memOutB;
    assign memSide.dmOut    = memDmOut;
    assign memSide.pc       = memPc;
    assign memSide.hi       = memHi;
    assign memSide.lo       = memLo;
    assign memSide.dst      = memDst;
    assign memSide.wbSel    = memWbSel;
    assign memSide.loadType = memLoadType;
    assign memSide.regsWr   = memRegsWr;

    // MEM/WB pipeline register.
    wbStageReg u_wbStageReg (
        .clk     (clk),
        .rstN    (rstN),
        .wbFlush (wbFlush),
        .wbWr    (wbWr),
        .memSide (memSide.consumer),
        .wbSide  (wbSide.producer)
    );

    wbResult u_wbResult (
        .wbSide  (wbSide.consumer),
        .wbValue (wbValue)
    );

    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .wbSide  (wbSide.consumer),
        .wbValue (wbValue),
        .rAddr1  (rAddr1),
        .rAddr2  (rAddr2),
        .rData1  (rData1),
        .rData2  (rData2),
        .hiOut   (hiOut),
        .loOut   (loOut)
    );

endmodule

//--- sim/tbWbTop.sv
`timescale 1ns/1ps

module tbWbTop;
    import wbPkg::*;

    localparam int timeoutCycles = 1500;    // well beyond the directed tests.

    logic      clk;
    logic      rstN;
    logic      wbFlush;
    logic      wbWr;
    word_t     memAluOut;
    word_t     memOutB;
    word_t     memDmOut;
    word_t     memPc;
    word_t     memHi;
    word_t     memLo;
    regIdx_t   memDst;
    wbSel_t    memWbSel;
    loadType_t memLoadType;
    regsWr_t   memRegsWr;
    regIdx_t   rAddr1;
    regIdx_t   rAddr2;
    word_t     rData1;
    word_t     rData2;
    word_t     hiOut;
    word_t     loOut;

    word_t     model [32];          // expected gpr contents.
    word_t     modelHi;
    word_t     modelLo;
    int        cycleCount;

    wbTop u_wbTop (
        .clk         (clk),
        .rstN        (rstN),
        .wbFlush     (wbFlush),
        .wbWr        (wbWr),
        .memAluOut   (memAluOut),
        .memOutB     (memOutB),
        .memDmOut    (memDmOut),
        .memPc       (memPc),
        .memHi       (memHi),
        .memLo       (memLo),
        .memDst      (memDst),
        .memWbSel    (memWbSel),
        .memLoadType (memLoadType),
        .memRegsWr   (memRegsWr),
        .rAddr1      (rAddr1),
        .rAddr2      (rAddr2),
        .rData1      (rData1),
        .rData2      (rData2),
        .hiOut       (hiOut),
        .loOut       (loOut)
    );

    always #20 clk = ~clk;          // 40 ns period.

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkIdx(input string name, input regIdx_t exp, input regIdx_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    function automatic regsWr_t makeWr(input logic rf, input logic hi, input logic lo);
        regsWr_t wr;
        wr.rfWr = rf;
        wr.hiWr = hi;
        wr.loWr = lo;
        return wr;
    endfunction

    // lane picked by shifting the word down, little endian.
    function automatic word_t expectedLoad(input loadType_t lt, input word_t addr,
                                           input word_t dm);
        word_t shifted;
        word_t result;
        case (lt.size)
            sizeByte: begin
                shifted = dm >> (8 * addr[1:0]);
                result = shifted & 32'h0000_00ff;
                if (lt.signExt && shifted[7]) begin
                    result = result | 32'hffff_ff00;
                end
            end
            sizeHalf: begin
                shifted = dm >> (16 * addr[1]);
                result = shifted & 32'h0000_ffff;
                if (lt.signExt && shifted[15]) begin
                    result = result | 32'hffff_0000;
                end
            end
            default: result = dm;
        endcase
        return result;
    endfunction

    task automatic clearModel();
        foreach (model[i]) begin
            model[i] = '0;
        end
        modelHi = '0;
        modelLo = '0;
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    // one instruction through the stage register, model follows at the edge.
    task automatic commit(input word_t expValue);
        wbWr = 1'b1;
        @(posedge clk);
        if (memRegsWr.rfWr && memDst != '0) begin
            model[memDst] = expValue;
        end
        if (memRegsWr.hiWr) begin
            modelHi = memHi;
        end
        if (memRegsWr.loWr) begin
            modelLo = memLo;
        end
        #2;
        wbWr = 1'b0;
    endtask

    task automatic checkReg(input regIdx_t idx);
        rAddr1 = idx;
        rAddr2 = idx;
        #1;
        checkWord("rData1", model[idx], rData1);
        checkWord("rData2", model[idx], rData2);
    endtask

    task automatic checkHiLo();
        checkWord("hiOut", modelHi, hiOut);
        checkWord("loOut", modelLo, loOut);
    endtask

    task automatic checkAllRegs();
        stepCycle();
        for (int i = 0; i < 32; i++) begin
            rAddr1 = regIdx_t'(i);
            rAddr2 = regIdx_t'(31 - i);
            #1;
            checkWord("rData1", model[i], rData1);
            checkWord("rData2", model[31 - i], rData2);
        end
        checkHiLo();
        stepCycle();                // back on the drive slot.
    endtask

    task automatic testAluWrite();
        regIdx_t dsts [6] = '{5'd1, 5'd5, 5'd0, 5'd17, 5'd31, 5'd5};
        foreach (dsts[k]) begin
            memDst = dsts[k];
            memWbSel = selAlu;
            memAluOut = $urandom;
            memRegsWr = makeWr(1'b1, 1'b0, 1'b0);
            commit(memAluOut);
            checkReg(dsts[k]);      // bypass right after the edge.
        end
        checkAllRegs();
    endtask

    task automatic testLoads();
        loadType_t lt;
        regIdx_t   dst;
        dst = 5'd8;
        for (int s = 0; s < 3; s++) begin
            for (int x = 0; x < 2; x++) begin
                for (int off = 0; off < 4; off += (1 << s)) begin
                    lt.signExt = x[0];
                    lt.size = loadSize_t'(s);
                    memDst = dst;
                    memWbSel = selLoad;
                    memLoadType = lt;
                    memAluOut = ($urandom & 32'hffff_fffc) | off;
                    memDmOut = $urandom;
                    memRegsWr = makeWr(1'b1, 1'b0, 1'b0);
                    commit(expectedLoad(lt, memAluOut, memDmOut));
                    checkReg(dst);
                    dst = dst + 1'b1;
                end
            end
        end
        checkAllRegs();
    endtask

    task automatic testLinkMove();
        memDst = 5'd22;
        memWbSel = selLink;
        memPc = $urandom & 32'hffff_fffc;
        memAluOut = $urandom;
        memRegsWr = makeWr(1'b1, 1'b0, 1'b0);
        commit(memPc + 32'd8);      // return address past the delay slot.
        checkReg(5'd22);
        memDst = 5'd23;
        memWbSel = selOutB;
        memOutB = $urandom;
        commit(memOutB);
        checkReg(5'd23);
        checkAllRegs();
    endtask

    task automatic testHiLo();
        for (int p = 1; p < 4; p++) begin
            memDst = 5'd5;          // named but rfWr stays low.
            memWbSel = selAlu;
            memAluOut = $urandom;
            memHi = $urandom;
            memLo = $urandom;
            memRegsWr = makeWr(1'b0, p[1], p[0]);
            commit(memAluOut);
            checkHiLo();
            checkReg(5'd5);
        end
        checkAllRegs();
    endtask

    task automatic testFlushStall();
        memDst = 5'd5;
        memWbSel = selAlu;
        memAluOut = $urandom;
        memHi = $urandom;
        memLo = $urandom;
        memRegsWr = makeWr(1'b1, 1'b1, 1'b1);
        wbWr = 1'b1;
        wbFlush = 1'b1;
        stepCycle();
        wbWr = 1'b0;
        wbFlush = 1'b0;
        checkReg(5'd5);
        checkHiLo();
        checkAllRegs();
        memDst = 5'd4;
        memAluOut = $urandom;
        memRegsWr = makeWr(1'b1, 1'b0, 1'b0);
        commit(memAluOut);
        memDst = 5'd6;              // new inputs while stalled.
        memAluOut = $urandom;
        repeat (3) begin
            stepCycle();
            checkReg(5'd4);
            checkReg(5'd6);
        end
        commit(memAluOut);
        checkReg(5'd6);
        checkReg(5'd4);
        checkAllRegs();
    endtask

    task automatic testReset();
        for (int i = 0; i < 32; i++) begin
            memDst = regIdx_t'(i);
            memWbSel = selAlu;
            memAluOut = ($urandom & 32'hffff_ffe0) | i;
            memHi = $urandom;
            memLo = $urandom;
            memRegsWr = makeWr(1'b1, 1'b1, 1'b1);
            commit(memAluOut);
            rAddr1 = regIdx_t'(i);
            #1;
            checkIdx("rData1[4:0]", regIdx_t'(i), rData1[4:0]);
        end
        rstN = 1'b0;
        repeat (5) stepCycle();
        rstN = 1'b1;
        clearModel();
        checkAllRegs();
    endtask

    initial begin
        word_t seedValue;
        seedValue = $urandom(32'hee5f);
        clk = 1'b0;
        rstN = 1'b0;
        wbFlush = 1'b0;
        wbWr = 1'b0;
        memAluOut = '0;
        memOutB = '0;
        memDmOut = '0;
        memPc = '0;
        memHi = '0;
        memLo = '0;
        memDst = '0;
        memWbSel = selAlu;
        memLoadType = '0;
        memRegsWr = '0;
        rAddr1 = '0;
        rAddr2 = '0;
        cycleCount = 0;
        clearModel();
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        testAluWrite();
        testLoads();
        testLinkMove();
        testHiLo();
        testFlushStall();
        testReset();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- mipsWriteback.f
verilog/wbPkg.sv
verilog/wbBus.sv
verilog/wbStageReg.sv
verilog/wbResult.sv
verilog/regFile.sv
verilog/wbTop.sv
sim/tbWbTop.sv

//--- Bender.yml
package:
  name: mipsWriteback

sources:
  - verilog/wbPkg.sv
  - verilog/wbBus.sv
  - verilog/wbStageReg.sv
  - verilog/wbResult.sv
  - verilog/regFile.sv
  - verilog/wbTop.sv
  - target: simulation
    files:
      - sim/tbWbTop.sv
